//--- logic/cpu_consts.svh
`ifndef CPU_CONSTS_SVH
`define CPU_CONSTS_SVH

// Datapath widths.
`define ADDR_WIDTH    16
`define DATA_WIDTH    32

// Register file.
`define REG_COUNT     32
`define REG_IDX_WIDTH 5

`define OPCODE_WIDTH  6
`define RESET_PC      'h0000

`endif

//--- logic/isa_pkg.sv
`include "cpu_consts.svh"

package isa_pkg;

  typedef enum logic [`OPCODE_WIDTH-1:0] {
    OP_ADD  = 'd0,
    OP_SUB  = 'd1,
    OP_AND  = 'd2,
    OP_OR   = 'd3,
    OP_ADDI = 'd4,
    OP_LW   = 'd5,
    OP_SW   = 'd6,
    OP_BEQ  = 'd7,
    OP_JMP  = 'd8,
    OP_HALT = 'd9
  } opcode_e;

  typedef struct packed {
    opcode_e                                                  opcode;
    logic [`REG_IDX_WIDTH-1:0]                                rd;
    logic [`REG_IDX_WIDTH-1:0]                                ra;
    logic [`REG_IDX_WIDTH-1:0]                                rb;
    logic signed [`DATA_WIDTH-`OPCODE_WIDTH-3*`REG_IDX_WIDTH-1:0] imm;
  } instr_t;

  // Opcodes that write rd. Register 0 never counts as a destination.
  function automatic logic writes_reg(instr_t instr);
    return (instr.rd != '0) &&
           (instr.opcode inside {OP_ADD, OP_SUB, OP_AND, OP_OR, OP_ADDI, OP_LW});
  endfunction

endpackage

//--- logic/pipe_pkg.sv
`include "cpu_consts.svh"

package pipe_pkg;

  // ****************************************
  // Stage-to-stage items.
  // ****************************************

  typedef struct packed {
    logic                      valid;
    logic [`ADDR_WIDTH-1:0]    pc;
    isa_pkg::instr_t           instr;
    logic [`DATA_WIDTH-1:0]    ra_val;
    logic [`DATA_WIDTH-1:0]    rb_val;
  } dec_ex_t;

  typedef struct packed {
    logic                      valid;
    logic [`ADDR_WIDTH-1:0]    pc;
    isa_pkg::opcode_e          opcode;
    logic [`REG_IDX_WIDTH-1:0] rd;
    logic                      wr_en;
    logic [`DATA_WIDTH-1:0]    result;
    logic [`DATA_WIDTH-1:0]    store_data;
  } ex_mem_t;

  // ****************************************
  // Memory bus and retire trace.
  // ****************************************

  typedef struct packed {
    logic                      rd;
    logic                      wr;
    logic                      is_instr;
    logic [`ADDR_WIDTH-1:0]    addr;
    logic [`DATA_WIDTH-1:0]    wdata;
  } mem_req_t;

  typedef struct packed {
    logic                      valid;
    logic                      is_instr;
    logic [`DATA_WIDTH-1:0]    data;
  } mem_rsp_t;

  typedef struct packed {
    logic                      valid;
    logic [`ADDR_WIDTH-1:0]    pc;
    logic                      wr_en;
    logic [`REG_IDX_WIDTH-1:0] rd;
    logic [`DATA_WIDTH-1:0]    data;
  } retire_t;

endpackage

//--- logic/fetch_unit.sv
`timescale 1ns/1ps
`include "cpu_consts.svh"

module fetch_unit (
  input  logic                   clk_i,
  input  logic                   rst_i,
  input  logic                   redirect_i,
  input  logic [`ADDR_WIDTH-1:0] target_i,
  input  logic                   grant_i,
  input  pipe_pkg::mem_rsp_t     rsp_i,
  input  logic                   stall_i,
  output pipe_pkg::mem_req_t     req_o,
  output logic                   instr_valid_o,
  output isa_pkg::instr_t        instr_o,
  output logic [`ADDR_WIDTH-1:0] pc_o
);

  import isa_pkg::*;

  logic [`ADDR_WIDTH-1:0] pc_q;
  logic                   run_q;
  logic                   halted_q;
  logic                   pending_q;
  logic                   stale_q;
  logic                   hold_valid_q;
  instr_t                 hold_instr_q;
  logic [`ADDR_WIDTH-1:0] hold_pc_q;
  instr_t                 rsp_instr;
  logic                   rsp_hit;
  logic                   fill;

  assign rsp_instr = instr_t'(rsp_i.data);
  assign rsp_hit   = rsp_i.valid && rsp_i.is_instr;
  assign fill      = rsp_hit && !stale_q && !redirect_i;

  // One read at a time, only into an empty holding register.
  always_comb begin
    req_o          = '0;
    req_o.rd       = run_q && !halted_q && !pending_q && !hold_valid_q;
    req_o.is_instr = 1'b1;
    req_o.addr     = pc_q;
  end

  always_ff @(posedge clk_i) begin
    if (!rst_i) begin
      pc_q         <= `RESET_PC;
      run_q        <= 1'b0;
      halted_q     <= 1'b0;
      pending_q    <= 1'b0;
      stale_q      <= 1'b0;
      hold_valid_q <= 1'b0;
    end else begin
      run_q <= 1'b1;
      if (grant_i) begin
        pending_q <= 1'b1;
      end else if (rsp_hit) begin
        pending_q <= 1'b0;
        stale_q   <= 1'b0;
      end
      if (redirect_i) begin
        pc_q         <= target_i;
        halted_q     <= 1'b0;
        hold_valid_q <= 1'b0;
        // The read in flight belongs to the old path.
        if (grant_i || (pending_q && !rsp_hit)) begin
          stale_q <= 1'b1;
        end
      end else if (fill) begin
        pc_q         <= pc_q + `ADDR_WIDTH'(4);
        hold_valid_q <= 1'b1;
        halted_q     <= (rsp_instr.opcode == OP_HALT);
        hold_instr_q <= rsp_instr;
        hold_pc_q    <= pc_q;
      end else if (!stall_i) begin
        hold_valid_q <= 1'b0;
      end
    end
  end

  assign instr_valid_o = hold_valid_q;
  assign instr_o       = hold_instr_q;
  assign pc_o          = hold_pc_q;

  // A returning instruction never lands on a full holding register.
  assert property (@(posedge clk_i) disable iff (!rst_i)
    fill |-> !hold_valid_q);

endmodule

//--- logic/reg_bank.sv
`timescale 1ns/1ps
`include "cpu_consts.svh"

module reg_bank (
  input  logic                      clk_i,
  input  logic                      rst_i,
  input  logic [`REG_IDX_WIDTH-1:0] ra_idx_i,
  input  logic [`REG_IDX_WIDTH-1:0] rb_idx_i,
  input  logic                      wr_en_i,
  input  logic [`REG_IDX_WIDTH-1:0] wr_idx_i,
  input  logic [`DATA_WIDTH-1:0]    wr_data_i,
  output logic [`DATA_WIDTH-1:0]    ra_data_o,
  output logic [`DATA_WIDTH-1:0]    rb_data_o
);

  logic [`DATA_WIDTH-1:0] regs_q [`REG_COUNT];

  always_ff @(posedge clk_i) begin
    if (!rst_i) begin
      for (int i = 0; i < `REG_COUNT; i++) begin
        regs_q[i] <= '0;
      end
    end else if (wr_en_i && (wr_idx_i != '0)) begin
      regs_q[wr_idx_i] <= wr_data_i;
    end
  end

  // Register 0 reads as zero.
  assign ra_data_o = (ra_idx_i == '0) ? '0 : regs_q[ra_idx_i];
  assign rb_data_o = (rb_idx_i == '0) ? '0 : regs_q[rb_idx_i];

endmodule

//--- logic/decode_unit.sv
`timescale 1ns/1ps
`include "cpu_consts.svh"

module decode_unit (
  input  logic                      clk_i,
  input  logic                      rst_i,
  input  logic                      instr_valid_i,
  input  isa_pkg::instr_t           instr_i,
  input  logic [`ADDR_WIDTH-1:0]    pc_i,
  input  logic                      redirect_i,
  input  logic                      busy_i,
  input  logic [`DATA_WIDTH-1:0]    ra_data_i,
  input  logic [`DATA_WIDTH-1:0]    rb_data_i,
  input  logic                      retire_wr_i,
  input  logic [`REG_IDX_WIDTH-1:0] retire_idx_i,
  output logic                      stall_o,
  output logic [`REG_IDX_WIDTH-1:0] ra_idx_o,
  output logic [`REG_IDX_WIDTH-1:0] rb_idx_o,
  output pipe_pkg::dec_ex_t         ex_o
);

  import isa_pkg::*;

  logic [`REG_COUNT-1:0] pending_q;
  logic                  uses_ra;
  logic                  uses_rb;
  logic                  writes;
  logic                  hazard;
  logic                  accept;

  assign uses_ra = instr_i.opcode inside {OP_ADD, OP_SUB, OP_AND, OP_OR, OP_ADDI,
                                          OP_LW, OP_SW, OP_BEQ};
  assign uses_rb = instr_i.opcode inside {OP_ADD, OP_SUB, OP_AND, OP_OR, OP_SW, OP_BEQ};
  assign writes  = writes_reg(instr_i);

  // Sources wait for older writes. A second writer to the same rd waits too.
  assign hazard = (uses_ra && pending_q[instr_i.ra]) ||
                  (uses_rb && pending_q[instr_i.rb]) ||
                  (writes && pending_q[instr_i.rd]);

  assign stall_o  = busy_i || hazard;
  assign accept   = instr_valid_i && !stall_o && !redirect_i;
  assign ra_idx_o = instr_i.ra;
  assign rb_idx_o = instr_i.rb;

  // ****************************************
  // Scoreboard.
  // ****************************************

  always_ff @(posedge clk_i) begin
    if (!rst_i) begin
      pending_q <= '0;
    end else begin
      if (retire_wr_i) begin
        pending_q[retire_idx_i] <= 1'b0;
      end
      if (accept && writes) begin
        pending_q[instr_i.rd] <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_i) begin
      ex_o.valid <= 1'b0;
    end else begin
      if (redirect_i) begin
        ex_o.valid <= 1'b0;
      end else if (!busy_i) begin
        ex_o.valid <= accept;
      end
      if (accept) begin
        ex_o.pc     <= pc_i;
        ex_o.instr  <= instr_i;
        ex_o.ra_val <= ra_data_i;
        ex_o.rb_val <= rb_data_i;
      end
    end
  end

  assert property (@(posedge clk_i) disable iff (!rst_i) !pending_q[0]);

  // Every write that retires was issued through the scoreboard.
  assert property (@(posedge clk_i) disable iff (!rst_i)
    retire_wr_i |-> pending_q[retire_idx_i]);

endmodule

//--- logic/execute_unit.sv
`timescale 1ns/1ps
`include "cpu_consts.svh"

module execute_unit (
  input  logic                   clk_i,
  input  logic                   rst_i,
  input  pipe_pkg::dec_ex_t      ex_i,
  input  logic                   busy_i,
  output logic                   redirect_o,
  output logic [`ADDR_WIDTH-1:0] target_o,
  output pipe_pkg::ex_mem_t      mem_o
);

  import isa_pkg::*;

  logic [`DATA_WIDTH-1:0] imm_ext;
  logic [`DATA_WIDTH-1:0] result;
  logic                   taken;

  assign imm_ext = `DATA_WIDTH'(signed'(ex_i.instr.imm));

  // ALU result, or the address for loads and stores.
  always_comb begin
    case (ex_i.instr.opcode)
      OP_ADD:                result = ex_i.ra_val + ex_i.rb_val;
      OP_SUB:                result = ex_i.ra_val - ex_i.rb_val;
      OP_AND:                result = ex_i.ra_val & ex_i.rb_val;
      OP_OR:                 result = ex_i.ra_val | ex_i.rb_val;
      OP_ADDI, OP_LW, OP_SW: result = ex_i.ra_val + imm_ext;
      default:               result = '0;
    endcase
  end

  always_comb begin
    taken    = 1'b0;
    target_o = ex_i.pc + {imm_ext[`ADDR_WIDTH-3:0], 2'b00};
    if (ex_i.instr.opcode == OP_JMP) begin
      taken    = 1'b1;
      target_o = `ADDR_WIDTH'({ex_i.instr.imm, 2'b00});
    end else if (ex_i.instr.opcode == OP_BEQ) begin
      taken = (ex_i.ra_val == ex_i.rb_val);
    end
  end

  // Pulses once, in the cycle the branch moves on.
  assign redirect_o = ex_i.valid && !busy_i && taken;

  always_ff @(posedge clk_i) begin
    if (!rst_i) begin
      mem_o.valid <= 1'b0;
    end else if (!busy_i) begin
      mem_o.valid      <= ex_i.valid;
      mem_o.pc         <= ex_i.pc;
      mem_o.opcode     <= ex_i.instr.opcode;
      mem_o.rd         <= ex_i.instr.rd;
      mem_o.wr_en      <= writes_reg(ex_i.instr);
      mem_o.result     <= result;
      mem_o.store_data <= ex_i.rb_val;
    end
  end

endmodule

//--- logic/mem_unit.sv
`timescale 1ns/1ps
`include "cpu_consts.svh"

module mem_unit (
  input  logic                      clk_i,
  input  logic                      rst_i,
  input  pipe_pkg::ex_mem_t         mem_i,
  input  logic                      grant_i,
  input  pipe_pkg::mem_rsp_t        rsp_i,
  output pipe_pkg::mem_req_t        req_o,
  output logic                      busy_o,
  output logic                      wb_en_o,
  output logic [`REG_IDX_WIDTH-1:0] wb_idx_o,
  output logic [`DATA_WIDTH-1:0]    wb_data_o,
  output pipe_pkg::retire_t         retire_o
);

  import isa_pkg::*;

  typedef enum logic [1:0] {
    IDLE,
    REQ,
    WAIT
  } state_e;

  state_e state_q;
  logic   is_load;
  logic   is_store;
  logic   rsp_hit;
  logic   done;

  assign is_load  = mem_i.valid && (mem_i.opcode == OP_LW);
  assign is_store = mem_i.valid && (mem_i.opcode == OP_SW);
  assign rsp_hit  = rsp_i.valid && !rsp_i.is_instr;

  // Stores end on their grant, loads on the data response.
  assign done   = ((state_q == REQ) && grant_i && is_store) ||
                  ((state_q == WAIT) && rsp_hit);
  assign busy_o = (is_load || is_store) && !done;

  always_comb begin
    req_o       = '0;
    req_o.rd    = (state_q == REQ) && is_load;
    req_o.wr    = (state_q == REQ) && is_store;
    req_o.addr  = mem_i.result[`ADDR_WIDTH-1:0];
    req_o.wdata = mem_i.store_data;
  end

  always_ff @(posedge clk_i) begin
    if (!rst_i) begin
      state_q        <= IDLE;
      retire_o.valid <= 1'b0;
    end else begin
      retire_o.valid <= 1'b0;
      case (state_q)
        IDLE: begin
          if (is_load || is_store) begin
            state_q <= REQ;
          end else begin
            retire_o.valid <= mem_i.valid;
          end
        end
        REQ: begin
          if (grant_i && is_load) begin
            state_q <= WAIT;
          end else if (grant_i) begin
            state_q        <= IDLE;
            retire_o.valid <= 1'b1;
          end
        end
        WAIT: begin
          if (rsp_hit) begin
            state_q        <= IDLE;
            retire_o.valid <= 1'b1;
          end
        end
        default: state_q <= IDLE;
      endcase
      retire_o.pc    <= mem_i.pc;
      retire_o.wr_en <= mem_i.wr_en;
      retire_o.rd    <= mem_i.rd;
      retire_o.data  <= (state_q == WAIT) ? rsp_i.data : mem_i.result;
    end
  end

  assign wb_en_o   = retire_o.valid && retire_o.wr_en;
  assign wb_idx_o  = retire_o.rd;
  assign wb_data_o = retire_o.data;

  assert property (@(posedge clk_i) disable iff (!rst_i)
    (state_q == WAIT) |-> !retire_o.valid);

endmodule

//--- logic/bus_arbiter.sv
`timescale 1ns/1ps

module bus_arbiter (
  input  logic               clk_i,
  input  logic               rst_i,
  input  pipe_pkg::mem_req_t fetch_req_i,
  input  pipe_pkg::mem_req_t data_req_i,
  input  pipe_pkg::mem_rsp_t rsp_i,
  output logic               fetch_grant_o,
  output logic               data_grant_o,
  output pipe_pkg::mem_req_t bus_req_o
);

  logic outstanding_q;
  logic data_wants;

  // Memory unit has fixed priority over fetch.
  assign data_wants    = data_req_i.rd || data_req_i.wr;
  assign data_grant_o  = !outstanding_q && data_wants;
  assign fetch_grant_o = !outstanding_q && !data_wants && fetch_req_i.rd;

  always_comb begin
    bus_req_o = '0;
    if (data_grant_o) begin
      bus_req_o = data_req_i;
    end else if (fetch_grant_o) begin
      bus_req_o = fetch_req_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_i) begin
      outstanding_q <= 1'b0;
    end else if (rsp_i.valid) begin
      outstanding_q <= 1'b0;
    end else if (bus_req_o.rd) begin
      outstanding_q <= 1'b1;
    end
  end

  // The granted unit matches the tag on the bus.
  assert property (@(posedge clk_i) disable iff (!rst_i)
    (fetch_grant_o || data_grant_o) |-> (bus_req_o.is_instr == fetch_grant_o));

  // A response only ends a read that was granted.
  assert property (@(posedge clk_i) disable iff (!rst_i)
    rsp_i.valid |-> outstanding_q);

endmodule

//--- logic/cpu.sv
`timescale 1ns/1ps
`include "cpu_consts.svh"

module cpu (
  input  logic               clk_i,
  input  logic               rst_i,
  input  pipe_pkg::mem_rsp_t mem_rsp_i,
  output pipe_pkg::mem_req_t mem_req_o,
  output pipe_pkg::retire_t  retire_o
);

  import isa_pkg::*;
  import pipe_pkg::*;

  // ****************************************
  // Interconnect.
  // ****************************************

  mem_req_t                  fetch_req;
  mem_req_t                  data_req;
  logic                      fetch_grant;
  logic                      data_grant;
  logic                      redirect;
  logic [`ADDR_WIDTH-1:0]    target;
  logic                      stall;
  logic                      instr_valid;
  instr_t                    instr;
  logic [`ADDR_WIDTH-1:0]    instr_pc;
  logic [`REG_IDX_WIDTH-1:0] ra_idx;
  logic [`REG_IDX_WIDTH-1:0] rb_idx;
  logic [`DATA_WIDTH-1:0]    ra_data;
  logic [`DATA_WIDTH-1:0]    rb_data;
  dec_ex_t                   dec_ex;
  ex_mem_t                   ex_mem;
  logic                      busy;
  logic                      wb_en;
  logic [`REG_IDX_WIDTH-1:0] wb_idx;
  logic [`DATA_WIDTH-1:0]    wb_data;

  fetch_unit fetch_unit (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .redirect_i    (redirect),
    .target_i      (target),
    .grant_i       (fetch_grant),
    .rsp_i         (mem_rsp_i),
    .stall_i       (stall),
    .req_o         (fetch_req),
    .instr_valid_o (instr_valid),
    .instr_o       (instr),
    .pc_o          (instr_pc)
  );

  reg_bank reg_bank (
    .clk_i     (clk_i),
    .rst_i     (rst_i),
    .ra_idx_i  (ra_idx),
    .rb_idx_i  (rb_idx),
    .wr_en_i   (wb_en),
    .wr_idx_i  (wb_idx),
    .wr_data_i (wb_data),
    .ra_data_o (ra_data),
    .rb_data_o (rb_data)
  );

  decode_unit decode_unit (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .instr_valid_i (instr_valid),
    .instr_i       (instr),
    .pc_i          (instr_pc),
    .redirect_i    (redirect),
    .busy_i        (busy),
    .ra_data_i     (ra_data),
    .rb_data_i     (rb_data),
    .retire_wr_i   (wb_en),
    .retire_idx_i  (wb_idx),
    .stall_o       (stall),
    .ra_idx_o      (ra_idx),
    .rb_idx_o      (rb_idx),
    .ex_o          (dec_ex)
  );

  execute_unit execute_unit (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .ex_i       (dec_ex),
    .busy_i     (busy),
    .redirect_o (redirect),
    .target_o   (target),
    .mem_o      (ex_mem)
  );

  mem_unit mem_unit (
    .clk_i     (clk_i),
    .rst_i     (rst_i),
    .mem_i     (ex_mem),
    .grant_i   (data_grant),
    .rsp_i     (mem_rsp_i),
    .req_o     (data_req),
    .busy_o    (busy),
    .wb_en_o   (wb_en),
    .wb_idx_o  (wb_idx),
    .wb_data_o (wb_data),
    .retire_o  (retire_o)
  );

  bus_arbiter bus_arbiter (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .fetch_req_i   (fetch_req),
    .data_req_i    (data_req),
    .rsp_i         (mem_rsp_i),
    .fetch_grant_o (fetch_grant),
    .data_grant_o  (data_grant),
    .bus_req_o     (mem_req_o)
  );

endmodule

//--- dv/tb_clock.sv
`timescale 1ns/1ps

module tb_clock (
  output logic clk_o,
  output logic rst_o
);

  localparam time HALF_PERIOD = 20ns;

  initial begin
    clk_o = 1'b0;
    forever #(HALF_PERIOD) clk_o = ~clk_o;
  end

  // Reset covers three rising edges and lifts on a falling edge.
  initial begin
    rst_o = 1'b0;
    repeat (3) @(posedge clk_o);
    @(negedge clk_o);
    rst_o <= 1'b1;
  end

endmodule

//--- dv/cpu_tb.sv
`timescale 1ns/1ps
`include "cpu_consts.svh"

module cpu_tb;

  import isa_pkg::*;
  import pipe_pkg::*;

  localparam int PROG_LEN   = 19;
  localparam int MAX_CYCLES = PROG_LEN * 4 * 8;

  logic                   clk_i;
  logic                   rst_i;
  mem_rsp_t               mem_rsp = '0;
  mem_req_t               mem_req;
  retire_t                retire;
  logic [31:0]            mem [256];
  logic [31:0]            ref_mem [256];
  logic [31:0]            model_regs [`REG_COUNT];
  logic [`ADDR_WIDTH-1:0] model_pc;
  logic [15:0]            lfsr = 16'd17660;
  logic                   read_busy;
  logic                   read_tag;
  logic [`ADDR_WIDTH-1:0] read_addr;
  int                     read_lat;
  logic                   req_seen;
  logic                   halt_retired;
  int                     cycles = 0;
  int                     mismatches = 0;
  int                     failures = 0;
  instr_t                 cur;
  logic [31:0]            imm_ext;
  logic [31:0]            ra_v;
  logic [31:0]            rb_v;
  logic [31:0]            exp_data;
  logic                   exp_wr_en;
  logic [`ADDR_WIDTH-1:0] exp_addr;
  logic [`ADDR_WIDTH-1:0] exp_next_pc;

  tb_clock clock_gen (
    .clk_o (clk_i),
    .rst_o (rst_i)
  );

  cpu UUT (
    .clk_i     (clk_i),
    .rst_i     (rst_i),
    .mem_rsp_i (mem_rsp),
    .mem_req_o (mem_req),
    .retire_o  (retire)
  );

  function automatic logic [31:0] make_instr(opcode_e op, int rd, int ra, int rb, int imm);
    return {op, 5'(rd), 5'(ra), 5'(rb), 11'(imm)};
  endfunction

  // Words 11, 14 and 15 are dead code behind the taken BEQ and the JMP.
  function automatic logic [31:0] program_word(int idx);
    case (idx)
      0:       return make_instr(OP_ADDI, 1, 0, 0, 5);
      1:       return make_instr(OP_ADDI, 2, 0, 0, 7);
      2:       return make_instr(OP_ADD, 3, 1, 2, 0);
      3:       return make_instr(OP_SUB, 4, 3, 1, 0);
      4:       return make_instr(OP_AND, 5, 3, 2, 0);
      5:       return make_instr(OP_OR, 6, 5, 1, 0);
      6:       return make_instr(OP_SW, 0, 0, 3, 512);
      7:       return make_instr(OP_LW, 7, 0, 0, 512);
      8:       return make_instr(OP_ADD, 8, 7, 7, 0);
      9:       return make_instr(OP_LW, 9, 0, 0, 516);
      10:      return make_instr(OP_BEQ, 0, 4, 2, 2);
      11:      return make_instr(OP_ADDI, 10, 0, 0, 99);
      12:      return make_instr(OP_BEQ, 0, 1, 2, 5);
      13:      return make_instr(OP_JMP, 0, 0, 0, 16);
      14:      return make_instr(OP_ADDI, 11, 0, 0, 1);
      15:      return make_instr(OP_ADDI, 12, 0, 0, 2);
      16:      return make_instr(OP_ADD, 13, 9, 8, 0);
      17:      return make_instr(OP_SW, 0, 1, 13, 515);
      18:      return make_instr(OP_HALT, 0, 0, 0, 0);
      default: return {16'hd0da, 8'(idx), ~8'(idx)};
    endcase
  endfunction

  // Galois LFSR with taps 0xB400.
  function automatic logic take_bit();
    logic out;
    out  = lfsr[0];
    lfsr = {1'b0, lfsr[15:1]} ^ (out ? 16'hb400 : 16'h0000);
    return out;
  endfunction

  task automatic report_mismatch(input string sig, input logic [31:0] exp_v,
                                 input logic [31:0] act_v);
    mismatches++;
    $display("MISMATCH t=%0t %s expected=%h actual=%h", $time, sig, exp_v, act_v);
  endtask

  task automatic report_failure(input string what);
    failures++;
    $display("ERROR t=%0t %s", $time, what);
  endtask

  // ****************************************
  // Memory model.
  // ****************************************

  always @(negedge clk_i) begin : mem_model
    logic b0;
    logic b1;
    mem_rsp <= '0;
    if (!rst_i) begin
      read_busy = 1'b0;
      req_seen  = 1'b0;
      for (int i = 0; i < 256; i++) begin
        mem[i] = program_word(i);
      end
    end else begin
      if (read_busy) begin
        read_lat = read_lat - 1;
        if (read_lat == 0) begin
          mem_rsp   <= '{valid: 1'b1, is_instr: read_tag, data: mem[read_addr[9:2]]};
          read_busy = 1'b0;
        end
      end
      if (mem_req.rd) begin
        b0        = take_bit();
        b1        = take_bit();
        read_busy = 1'b1;
        read_tag  = mem_req.is_instr;
        read_addr = mem_req.addr;
        read_lat  = 1 + {b1, b0};
      end
      if (mem_req.wr) begin
        mem[mem_req.addr[9:2]] = mem_req.wdata;
      end
      if (mem_req.rd || mem_req.wr) begin
        req_seen = 1'b1;
      end
    end
  end

  // ****************************************
  // Instruction-set reference model.
  // ****************************************

  always_comb begin
    cur         = instr_t'(ref_mem[model_pc[9:2]]);
    imm_ext     = {{21{cur.imm[10]}}, cur.imm};
    ra_v        = model_regs[cur.ra];
    rb_v        = model_regs[cur.rb];
    exp_addr    = ra_v[15:0] + imm_ext[15:0];
    exp_data    = '0;
    exp_next_pc = model_pc + 16'd4;
    case (cur.opcode)
      OP_ADD:  exp_data = ra_v + rb_v;
      OP_SUB:  exp_data = ra_v - rb_v;
      OP_AND:  exp_data = ra_v & rb_v;
      OP_OR:   exp_data = ra_v | rb_v;
      OP_ADDI: exp_data = ra_v + imm_ext;
      OP_LW:   exp_data = ref_mem[exp_addr[9:2]];
      OP_BEQ: begin
        if (ra_v == rb_v) begin
          exp_next_pc = model_pc + {imm_ext[13:0], 2'b00};
        end
      end
      OP_JMP:  exp_next_pc = 16'({cur.imm, 2'b00});
      default: ;
    endcase
    exp_wr_en = (cur.rd != '0) &&
                (cur.opcode inside {OP_ADD, OP_SUB, OP_AND, OP_OR, OP_ADDI, OP_LW});
  end

  always @(negedge clk_i) begin
    if (!rst_i) begin
      model_pc     = `RESET_PC;
      halt_retired = 1'b0;
      for (int i = 0; i < `REG_COUNT; i++) begin
        model_regs[i] = '0;
      end
      for (int i = 0; i < 256; i++) begin
        ref_mem[i] = program_word(i);
      end
    end else if (retire.valid) begin
      if (exp_wr_en) begin
        model_regs[cur.rd] = exp_data;
      end
      if (cur.opcode == OP_SW) begin
        ref_mem[exp_addr[9:2]] = rb_v;
      end
      if (cur.opcode == OP_HALT) begin
        halt_retired = 1'b1;
      end
      model_pc = exp_next_pc;
    end
  end

  // ****************************************
  // Checks.
  // ****************************************

  assert property (@(negedge clk_i) !rst_i |-> !(mem_req.rd || mem_req.wr || retire.valid))
    else report_failure("bus request or retire while reset is asserted");

  assert property (@(negedge clk_i) disable iff (!rst_i)
    (mem_req.rd || mem_req.wr) && !req_seen |->
      mem_req.rd && mem_req.is_instr && (mem_req.addr == `RESET_PC))
    else report_failure("first request after reset is not an instruction read of the reset PC");

  assert property (@(negedge clk_i) disable iff (!rst_i)
    (mem_req.rd || mem_req.wr) |-> !read_busy)
    else report_failure("bus request while a read is still outstanding");

  assert property (@(negedge clk_i) disable iff (!rst_i)
    retire.valid |-> (retire.pc == model_pc))
    else report_mismatch("retire_o.pc", $sampled(model_pc), $sampled(retire.pc));

  assert property (@(negedge clk_i) disable iff (!rst_i)
    retire.valid |-> (retire.wr_en == exp_wr_en))
    else report_mismatch("retire_o.wr_en", $sampled(exp_wr_en), $sampled(retire.wr_en));

  assert property (@(negedge clk_i) disable iff (!rst_i)
    retire.valid && exp_wr_en |-> (retire.rd == cur.rd))
    else report_mismatch("retire_o.rd", $sampled(cur.rd), $sampled(retire.rd));

  assert property (@(negedge clk_i) disable iff (!rst_i)
    retire.valid && exp_wr_en |-> (retire.data == exp_data))
    else report_mismatch("retire_o.data", $sampled(exp_data), $sampled(retire.data));

  assert property (@(negedge clk_i) disable iff (!rst_i)
    mem_req.wr |-> (cur.opcode == OP_SW))
    else report_failure("bus write while the next instruction to retire is not SW");

  assert property (@(negedge clk_i) disable iff (!rst_i)
    mem_req.wr && (cur.opcode == OP_SW) |-> (mem_req.addr == exp_addr))
    else report_mismatch("mem_req_o.addr", $sampled(exp_addr), $sampled(mem_req.addr));

  assert property (@(negedge clk_i) disable iff (!rst_i)
    mem_req.wr && (cur.opcode == OP_SW) |-> (mem_req.wdata == rb_v))
    else report_mismatch("mem_req_o.wdata", $sampled(rb_v), $sampled(mem_req.wdata));

  assert property (@(negedge clk_i) disable iff (!rst_i)
    halt_retired |-> !(mem_req.rd || mem_req.wr || retire.valid))
    else report_failure("bus request or retire after HALT retired");

  always @(posedge clk_i) begin
    cycles <= cycles + 1;
  end

  initial begin
    wait (rst_i);
    while (!halt_retired && cycles < MAX_CYCLES) begin
      @(negedge clk_i);
    end
    if (halt_retired) begin
      // A quiet stretch shows that nothing is fetched after HALT.
      repeat (8) @(negedge clk_i);
    end else begin
      report_failure($sformatf("HALT did not retire within %0d cycles", MAX_CYCLES));
    end
    $display("Checks done: %0d mismatches, %0d other errors", mismatches, failures);
    if (mismatches == 0 && failures == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

//--- src.f
+incdir+logic
logic/isa_pkg.sv
logic/pipe_pkg.sv
logic/fetch_unit.sv
logic/reg_bank.sv
logic/decode_unit.sv
logic/execute_unit.sv
logic/mem_unit.sv
logic/bus_arbiter.sv
logic/cpu.sv
dv/tb_clock.sv
dv/cpu_tb.sv
